// ==== design/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data path and pc width
`define XLEN 32

// architectural integer registers
`define NUM_REGS 32

// register index width, log2 of NUM_REGS
`define REG_W 5

`endif

// ==== design/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	// base opcodes, instr[6:0]
	parameter logic [6:0] OP_REG    = 7'b0110011;
	parameter logic [6:0] OP_IMM    = 7'b0010011;
	parameter logic [6:0] OP_LOAD   = 7'b0000011;
	parameter logic [6:0] OP_STORE  = 7'b0100011;
	parameter logic [6:0] OP_BRANCH = 7'b1100011;
	parameter logic [6:0] OP_JAL    = 7'b1101111;
	parameter logic [6:0] OP_JALR   = 7'b1100111;
	parameter logic [6:0] OP_LUI    = 7'b0110111;
	parameter logic [6:0] OP_AUIPC  = 7'b0010111;
	parameter logic [6:0] OP_SYSTEM = 7'b1110011;

	// alu function, {instr[30], funct3} for arithmetic
	typedef logic [3:0] alu_fn_t;
	parameter alu_fn_t ALU_ADD  = 4'b0000;
	// beq and bne compare through a subtract
	parameter alu_fn_t ALU_SUB  = 4'b1000;
	parameter alu_fn_t ALU_SLT  = 4'b0010;
	parameter alu_fn_t ALU_SLTU = 4'b0011;
	parameter alu_fn_t ALU_BGE  = 4'b1001;
	parameter alu_fn_t ALU_BGEU = 4'b1010;

	// writeback result source
	typedef logic [2:0] fn_sel_t;
	parameter fn_sel_t FN_ALU    = 3'b000;
	parameter fn_sel_t FN_PC4    = 3'b001;
	parameter fn_sel_t FN_MULDIV = 3'b010;
	parameter fn_sel_t FN_IMM    = 3'b011;
	parameter fn_sel_t FN_AUIPC  = 3'b100;
	parameter fn_sel_t FN_SYS    = 3'b110;
	parameter fn_sel_t FN_LOAD   = 3'b111;

	// memory access kind
	typedef logic [3:0] mem_op_t;
	parameter mem_op_t MEM_NONE = 4'b0000;
	parameter mem_op_t MEM_LB   = 4'b0001;
	parameter mem_op_t MEM_LH   = 4'b0010;
	parameter mem_op_t MEM_LW   = 4'b0011;
	parameter mem_op_t MEM_LBU  = 4'b0100;
	parameter mem_op_t MEM_LHU  = 4'b0101;
	parameter mem_op_t MEM_SB   = 4'b1110;
	parameter mem_op_t MEM_SH   = 4'b1111;
	parameter mem_op_t MEM_SW   = 4'b1000;

	// mul/div unit op, same as funct3
	typedef logic [2:0] muldiv_op_t;

	// operand b source
	typedef logic [1:0] b_sel_t;
	parameter b_sel_t B_REG   = 2'b00;
	parameter b_sel_t B_IMM   = 2'b01;
	parameter b_sel_t B_SHAMT = 2'b10;

endpackage

`default_nettype wire

// ==== design/pipe_pkg.sv ====
`default_nettype none
`include "core_cfg.svh"

package pipe_pkg;

	// raw item from fetch
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [31:0]      instr;
	} fetch_pkt_t;

	// decoded bundle handed to execute
	typedef struct packed {
		logic [`XLEN-1:0]   pc;
		logic [`REG_W-1:0]  rd;
		logic [`REG_W-1:0]  rs1;
		logic [`REG_W-1:0]  rs2;
		logic [`XLEN-1:0]   imm;
		isa_pkg::b_sel_t    b_sel;
		logic               we;
		isa_pkg::fn_sel_t   fn;
		isa_pkg::alu_fn_t   alu_fn;
		isa_pkg::muldiv_op_t muldiv_op;
		isa_pkg::mem_op_t   mem_op;
		logic [1:0]         pcselect;
		logic               btype;
		logic               bneq;
		logic               j;
		logic               jr;
		logic               lui;
		logic               auipc;
		// system return flags
		logic               ecall;
		logic               mret;
		logic               sret;
		logic               uret;
		logic               illegal;
	} issue_pkt_t;

endpackage

`default_nettype wire

// ==== design/pipe_stage.sv ====
`default_nettype none

module pipe_stage #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     i_clk,
	input  logic     i_rst_n,
	// upstream side
	input  logic     i_valid,
	output logic     o_ready,
	input  payload_t i_data,
	// downstream side
	output logic     o_valid,
	input  logic     i_ready,
	output payload_t o_data
);

	logic     full_q;
	payload_t data_q;

	// free slot, or the held item leaves this cycle
	assign o_ready = ~full_q | i_ready;
	assign o_valid = full_q;
	assign o_data  = data_q;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			full_q <= 1'b0;
		end else if (o_ready) begin
			full_q <= i_valid;
		end
	end

	// payload only moves on a transfer
	always_ff @(posedge i_clk) begin
		if (i_valid && o_ready) begin
			data_q <= i_data;
		end
	end

	// a stalled item must not change under the consumer
	hold_stable_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(o_valid && !i_ready) |=> $stable(o_data));

endmodule

`default_nettype wire

// ==== design/instr_decoder.sv ====
`default_nettype none

module instr_decoder (
	input  logic [31:0]         i_instr,
	// from commit
	input  logic                i_exception_pending,
	output isa_pkg::b_sel_t     o_b_sel,
	output logic                o_we,
	output isa_pkg::fn_sel_t    o_fn,
	output isa_pkg::alu_fn_t    o_alu_fn,
	output isa_pkg::muldiv_op_t o_muldiv_op,
	output isa_pkg::mem_op_t    o_mem_op,
	output logic [1:0]          o_pcselect,
	output logic                o_btype,
	output logic                o_bneq,
	output logic                o_j,
	output logic                o_jr,
	output logic                o_lui,
	output logic                o_auipc,
	output logic                o_ecall,
	output logic                o_mret,
	output logic                o_sret,
	output logic                o_uret,
	output logic                o_illegal
);

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [11:0] funct12;
	logic        is_reg, is_imm, is_load, is_store, is_branch;
	logic        is_jal, is_jalr, is_lui, is_auipc, is_system;
	logic        is_muldiv, is_alu_reg, is_shift_imm, alt_op;

	// instruction fields
	assign opcode  = i_instr[6:0];
	assign funct3  = i_instr[14:12];
	assign funct7  = i_instr[31:25];
	assign funct12 = i_instr[31:20];

	// opcode classes
	assign is_reg    = (opcode == isa_pkg::OP_REG);
	assign is_imm    = (opcode == isa_pkg::OP_IMM);
	assign is_load   = (opcode == isa_pkg::OP_LOAD);
	assign is_store  = (opcode == isa_pkg::OP_STORE);
	assign is_branch = (opcode == isa_pkg::OP_BRANCH);
	assign is_jal    = (opcode == isa_pkg::OP_JAL);
	assign is_jalr   = (opcode == isa_pkg::OP_JALR);
	assign is_lui    = (opcode == isa_pkg::OP_LUI);
	assign is_auipc  = (opcode == isa_pkg::OP_AUIPC);
	assign is_system = (opcode == isa_pkg::OP_SYSTEM);

	// funct7 0000001 selects the M extension
	assign is_muldiv    = is_reg & (funct7 == 7'b0000001);
	assign is_alu_reg   = is_reg & ~is_muldiv;
	assign is_shift_imm = is_imm & (funct3[1:0] == 2'b01);
	// instr[30] counts only for sub, sra and srai
	assign alt_op = i_instr[30] & ((is_alu_reg & (funct3 == 3'b000 || funct3 == 3'b101)) |
		(is_imm & (funct3 == 3'b101)));

	// system returns, funct3 000 with funct12 picking the level
	assign o_ecall = is_system & (funct3 == 3'b000) & (funct12 == 12'h000);
	assign o_uret  = is_system & (funct3 == 3'b000) & (funct12 == 12'h002);
	assign o_sret  = is_system & (funct3 == 3'b000) & (funct12 == 12'h102);
	assign o_mret  = is_system & (funct3 == 3'b000) & (funct12 == 12'h302);

	// control flow
	assign o_btype    = is_branch;
	assign o_bneq     = is_branch & (funct3 == 3'b001);
	assign o_j        = is_jal;
	assign o_jr       = is_jalr;
	assign o_lui      = is_lui;
	assign o_auipc    = is_auipc;
	assign o_pcselect = (is_branch | is_jal | is_jalr) ? 2'b10 : 2'b00;

	// pending exception kills the writeback
	assign o_we = (is_reg | is_imm | is_jal | is_jalr | is_load | is_lui | is_auipc) &
		~i_exception_pending;

	assign o_muldiv_op = is_muldiv ? funct3 : 3'b000;

	// operand b, address calc for loads and jalr takes the immediate
	assign o_b_sel = is_shift_imm ? isa_pkg::B_SHAMT :
		((is_imm | is_load | is_jalr) ? isa_pkg::B_IMM : isa_pkg::B_REG);

	always_comb begin
		o_alu_fn = isa_pkg::ALU_ADD;
		if (is_alu_reg || is_imm) begin
			o_alu_fn = {alt_op, funct3};
		end else if (is_branch) begin
			case (funct3)
				3'b000, 3'b001: o_alu_fn = isa_pkg::ALU_SUB;
				3'b100:         o_alu_fn = isa_pkg::ALU_SLT;
				3'b101:         o_alu_fn = isa_pkg::ALU_BGE;
				3'b110:         o_alu_fn = isa_pkg::ALU_SLTU;
				3'b111:         o_alu_fn = isa_pkg::ALU_BGEU;
				default:        o_alu_fn = isa_pkg::ALU_ADD;
			endcase
		end
	end

	// result source, first match wins
	always_comb begin
		if (is_load)                o_fn = isa_pkg::FN_LOAD;
		else if (is_jal || is_jalr) o_fn = isa_pkg::FN_PC4;
		else if (is_muldiv)         o_fn = isa_pkg::FN_MULDIV;
		else if (is_lui)            o_fn = isa_pkg::FN_IMM;
		else if (is_auipc)          o_fn = isa_pkg::FN_AUIPC;
		else if (is_system)         o_fn = isa_pkg::FN_SYS;
		else                        o_fn = isa_pkg::FN_ALU;
	end

	always_comb begin
		o_mem_op = isa_pkg::MEM_NONE;
		if (is_load) begin
			case (funct3)
				3'b000:  o_mem_op = isa_pkg::MEM_LB;
				3'b001:  o_mem_op = isa_pkg::MEM_LH;
				3'b010:  o_mem_op = isa_pkg::MEM_LW;
				3'b100:  o_mem_op = isa_pkg::MEM_LBU;
				3'b101:  o_mem_op = isa_pkg::MEM_LHU;
				default: o_mem_op = isa_pkg::MEM_NONE;
			endcase
		end else if (is_store) begin
			case (funct3)
				3'b000:  o_mem_op = isa_pkg::MEM_SB;
				3'b001:  o_mem_op = isa_pkg::MEM_SH;
				3'b010:  o_mem_op = isa_pkg::MEM_SW;
				default: o_mem_op = isa_pkg::MEM_NONE;
			endcase
		end
	end

	// unknown opcode or reserved funct3
	always_comb begin
		case (opcode)
			isa_pkg::OP_LOAD:   o_illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
			isa_pkg::OP_STORE:  o_illegal = funct3[2] || (funct3[1:0] == 2'b11);
			isa_pkg::OP_BRANCH: o_illegal = (funct3[2:1] == 2'b01);
			// csr access is not decoded here
			isa_pkg::OP_JALR, isa_pkg::OP_SYSTEM: o_illegal = (funct3 != 3'b000);
			isa_pkg::OP_REG, isa_pkg::OP_IMM, isa_pkg::OP_JAL,
			isa_pkg::OP_LUI, isa_pkg::OP_AUIPC:   o_illegal = 1'b0;
			default:            o_illegal = 1'b1;
		endcase
	end

	ret_onehot_a: assert final ($onehot0({o_ecall, o_mret, o_sret, o_uret}));

endmodule

`default_nettype wire

// ==== design/imm_gen.sv ====
`default_nettype none
`include "core_cfg.svh"

module imm_gen (
	input  logic [31:0]       i_instr,
	output logic [`XLEN-1:0]  o_imm
);

	logic [31:0] imm32;

	// format picked by opcode
	always_comb begin
		case (i_instr[6:0])
			// i-type
			isa_pkg::OP_IMM, isa_pkg::OP_LOAD, isa_pkg::OP_JALR:
				imm32 = {{20{i_instr[31]}}, i_instr[31:20]};
			// s-type, split across funct7 and rd fields
			isa_pkg::OP_STORE:
				imm32 = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
			// b-type, bit 0 always zero
			isa_pkg::OP_BRANCH:
				imm32 = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
					i_instr[11:8], 1'b0};
			// u-type, upper 20 bits
			isa_pkg::OP_LUI, isa_pkg::OP_AUIPC:
				imm32 = {i_instr[31:12], 12'b0};
			// j-type
			isa_pkg::OP_JAL:
				imm32 = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
					i_instr[30:21], 1'b0};
			// register ops and everything else carry no immediate
			default:
				imm32 = 32'b0;
		endcase
	end

	// widen to xlen with sign
	assign o_imm = {{(`XLEN-31){imm32[31]}}, imm32[30:0]};

endmodule

`default_nettype wire

// ==== design/scoreboard.sv ====
`default_nettype none
`include "core_cfg.svh"

module scoreboard (
	input  logic              i_clk,
	input  logic              i_rst_n,
	// sources and destination of the item in decode
	input  logic [`REG_W-1:0] i_rs1,
	input  logic [`REG_W-1:0] i_rs2,
	input  logic [`REG_W-1:0] i_rd,
	input  logic              i_use_rs1,
	input  logic              i_use_rs2,
	// item moves to issue this cycle
	input  logic              i_issue,
	input  logic              i_issue_we,
	// writeback release
	input  logic              i_wb_valid,
	input  logic [`REG_W-1:0] i_wb_rd,
	output logic              o_stall
);

	logic [`NUM_REGS-1:0] busy_q;

	// raw on either source, or waw on rd
	assign o_stall = (i_use_rs1 & busy_q[i_rs1]) | (i_use_rs2 & busy_q[i_rs2]) | busy_q[i_rd];

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			busy_q <= '0;
		end else begin
			if (i_wb_valid) begin
				busy_q[i_wb_rd] <= 1'b0;
			end
			// set comes last so it wins a same-edge clear
			if (i_issue && i_issue_we && (i_rd != '0)) begin
				busy_q[i_rd] <= 1'b1;
			end
		end
	end

	// x0 writes never mark busy, so leave them out
	wb_busy_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_wb_valid && (i_wb_rd != '0)) |-> busy_q[i_wb_rd]);

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`default_nettype none
`include "core_cfg.svh"

module decode_stage (
	input  logic                i_clk,
	input  logic                i_rst_n,
	// from fetch
	input  logic                i_in_valid,
	input  logic [`XLEN-1:0]    i_in_pc,
	input  logic [31:0]         i_in_instr,
	output logic                o_in_ready,
	// from commit
	input  logic                i_exception_pending,
	input  logic                i_wb_valid,
	input  logic [`REG_W-1:0]   i_wb_rd,
	// to execute
	output logic                o_out_valid,
	input  logic                i_out_ready,
	output logic [`XLEN-1:0]    o_out_pc,
	output logic [`REG_W-1:0]   o_out_rd,
	output logic [`REG_W-1:0]   o_out_rs1,
	output logic [`REG_W-1:0]   o_out_rs2,
	output logic [`XLEN-1:0]    o_out_imm,
	output isa_pkg::b_sel_t     o_out_b_sel,
	output logic                o_out_we,
	output isa_pkg::fn_sel_t    o_out_fn,
	output isa_pkg::alu_fn_t    o_out_alu_fn,
	output isa_pkg::muldiv_op_t o_out_muldiv_op,
	output isa_pkg::mem_op_t    o_out_mem_op,
	output logic [1:0]          o_out_pcselect,
	output logic                o_out_btype,
	output logic                o_out_bneq,
	output logic                o_out_j,
	output logic                o_out_jr,
	output logic                o_out_lui,
	output logic                o_out_auipc,
	output logic                o_out_ecall,
	output logic                o_out_mret,
	output logic                o_out_sret,
	output logic                o_out_uret,
	output logic                o_out_illegal
);

	pipe_pkg::fetch_pkt_t in_pkt, fetch_q;
	wire pipe_pkg::issue_pkt_t issue_d;
	pipe_pkg::issue_pkt_t      issue_q;
	logic fetch_valid, issue_ready, stall, use_rs1, use_rs2;

	assign in_pkt = '{pc: i_in_pc, instr: i_in_instr};

	pipe_stage #(.payload_t(pipe_pkg::fetch_pkt_t)) fetch_slot_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_valid(i_in_valid), .o_ready(o_in_ready), .i_data(in_pkt),
		.o_valid(fetch_valid), .i_ready(issue_ready & ~stall), .o_data(fetch_q)
	);

	// register numbers pass straight through
	assign issue_d.pc  = fetch_q.pc;
	assign issue_d.rd  = fetch_q.instr[11:7];
	assign issue_d.rs1 = fetch_q.instr[19:15];
	assign issue_d.rs2 = fetch_q.instr[24:20];

	instr_decoder instr_decoder_i (
		.i_instr(fetch_q.instr), .i_exception_pending(i_exception_pending),
		.o_b_sel(issue_d.b_sel), .o_we(issue_d.we), .o_fn(issue_d.fn),
		.o_alu_fn(issue_d.alu_fn), .o_muldiv_op(issue_d.muldiv_op),
		.o_mem_op(issue_d.mem_op), .o_pcselect(issue_d.pcselect),
		.o_btype(issue_d.btype), .o_bneq(issue_d.bneq), .o_j(issue_d.j),
		.o_jr(issue_d.jr), .o_lui(issue_d.lui), .o_auipc(issue_d.auipc),
		.o_ecall(issue_d.ecall), .o_mret(issue_d.mret), .o_sret(issue_d.sret),
		.o_uret(issue_d.uret), .o_illegal(issue_d.illegal)
	);

	imm_gen imm_gen_i (.i_instr(fetch_q.instr), .o_imm(issue_d.imm));

	// rs1 unused by lui, auipc and jal; rs2 only by reg, store, branch
	assign use_rs1 = ~(issue_d.lui | issue_d.auipc | issue_d.j);
	assign use_rs2 = (fetch_q.instr[6:0] == isa_pkg::OP_REG) |
		(fetch_q.instr[6:0] == isa_pkg::OP_STORE) | issue_d.btype;

	scoreboard scoreboard_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_rs1(issue_d.rs1), .i_rs2(issue_d.rs2), .i_rd(issue_d.rd),
		.i_use_rs1(use_rs1), .i_use_rs2(use_rs2),
		.i_issue(fetch_valid & ~stall & issue_ready), .i_issue_we(issue_d.we),
		.i_wb_valid(i_wb_valid), .i_wb_rd(i_wb_rd), .o_stall(stall)
	);

	pipe_stage #(.payload_t(pipe_pkg::issue_pkt_t)) issue_slot_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_valid(fetch_valid & ~stall), .o_ready(issue_ready), .i_data(issue_d),
		.o_valid(o_out_valid), .i_ready(i_out_ready), .o_data(issue_q)
	);

	// unpack held bundle
	assign o_out_pc        = issue_q.pc;
	assign o_out_rd        = issue_q.rd;
	assign o_out_rs1       = issue_q.rs1;
	assign o_out_rs2       = issue_q.rs2;
	assign o_out_imm       = issue_q.imm;
	assign o_out_b_sel     = issue_q.b_sel;
	assign o_out_we        = issue_q.we;
	assign o_out_fn        = issue_q.fn;
	assign o_out_alu_fn    = issue_q.alu_fn;
	assign o_out_muldiv_op = issue_q.muldiv_op;
	assign o_out_mem_op    = issue_q.mem_op;
	assign o_out_pcselect  = issue_q.pcselect;
	assign o_out_btype     = issue_q.btype;
	assign o_out_bneq      = issue_q.bneq;
	assign o_out_j         = issue_q.j;
	assign o_out_jr        = issue_q.jr;
	assign o_out_lui       = issue_q.lui;
	assign o_out_auipc     = issue_q.auipc;
	assign o_out_ecall     = issue_q.ecall;
	assign o_out_mret      = issue_q.mret;
	assign o_out_sret      = issue_q.sret;
	assign o_out_uret      = issue_q.uret;
	assign o_out_illegal   = issue_q.illegal;

endmodule

`default_nettype wire

// ==== tb/tb_decode_stage.sv ====
`default_nettype none
`include "core_cfg.svh"

module tb_decode_stage;

	// directed sweeps, then a random tail
	localparam int N_RANDOM = 30;
	localparam int N_TESTS  = 75 + N_RANDOM;

	logic                 i_clk, i_rst_n, i_in_valid, o_in_ready;
	logic [`XLEN-1:0]     i_in_pc;
	logic [31:0]          i_in_instr;
	logic                 i_exception_pending, i_wb_valid, i_out_ready, o_out_valid;
	logic [`REG_W-1:0]    i_wb_rd;
	wire pipe_pkg::issue_pkt_t act;
	pipe_pkg::issue_pkt_t exp_head;
	pipe_pkg::issue_pkt_t exp_mem [0:255];
	logic [31:0]          exp_reads [0:255];
	logic [31:0]          reads_head, tb_busy;
	logic [`REG_W-1:0]    wb_q [$];
	int                   wr_ptr, rd_ptr, bp_left, err_field, err_hazard, err_flow;
	integer               seed;
	logic                 in_took;
	logic [`XLEN-1:0]     pc_next;

	decode_stage dut_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_in_valid(i_in_valid), .i_in_pc(i_in_pc), .i_in_instr(i_in_instr),
		.o_in_ready(o_in_ready), .i_exception_pending(i_exception_pending),
		.i_wb_valid(i_wb_valid), .i_wb_rd(i_wb_rd),
		.o_out_valid(o_out_valid), .i_out_ready(i_out_ready),
		.o_out_pc(act.pc), .o_out_rd(act.rd), .o_out_rs1(act.rs1), .o_out_rs2(act.rs2),
		.o_out_imm(act.imm), .o_out_b_sel(act.b_sel), .o_out_we(act.we),
		.o_out_fn(act.fn), .o_out_alu_fn(act.alu_fn), .o_out_muldiv_op(act.muldiv_op),
		.o_out_mem_op(act.mem_op), .o_out_pcselect(act.pcselect),
		.o_out_btype(act.btype), .o_out_bneq(act.bneq), .o_out_j(act.j),
		.o_out_jr(act.jr), .o_out_lui(act.lui), .o_out_auipc(act.auipc),
		.o_out_ecall(act.ecall), .o_out_mret(act.mret), .o_out_sret(act.sret),
		.o_out_uret(act.uret), .o_out_illegal(act.illegal)
	);

	// oldest outstanding item
	assign exp_head   = exp_mem[rd_ptr];
	assign reads_head = exp_reads[rd_ptr];

	// reference decode of one instruction
	function automatic pipe_pkg::issue_pkt_t expect_decode(input logic [31:0] ins,
		input logic [`XLEN-1:0] pc, input logic exc);
		pipe_pkg::issue_pkt_t e;
		logic [2:0] f3;
		e = '0;
		f3 = ins[14:12];
		e.pc = pc;
		e.rd = ins[11:7];
		e.rs1 = ins[19:15];
		e.rs2 = ins[24:20];
		case (ins[6:0])
			isa_pkg::OP_REG: begin
				e.we = 1'b1;
				if (ins[31:25] == 7'h01) begin
					e.fn = 3'b010;
					e.muldiv_op = f3;
				end else begin
					e.alu_fn = {ins[30] & (f3 == 3'd0 || f3 == 3'd5), f3};
				end
			end
			isa_pkg::OP_IMM: begin
				e.we = 1'b1;
				e.alu_fn = {ins[30] & (f3 == 3'd5), f3};
				e.b_sel = (f3 == 3'd1 || f3 == 3'd5) ? 2'b10 : 2'b01;
				e.imm = 32'($signed(ins[31:20]));
			end
			isa_pkg::OP_LOAD: begin
				e.we = 1'b1;
				e.fn = 3'b111;
				e.b_sel = 2'b01;
				e.imm = 32'($signed(ins[31:20]));
				case (f3)
					3'd0: e.mem_op = 4'b0001;
					3'd1: e.mem_op = 4'b0010;
					3'd2: e.mem_op = 4'b0011;
					3'd4: e.mem_op = 4'b0100;
					3'd5: e.mem_op = 4'b0101;
					default: e.illegal = 1'b1;
				endcase
			end
			isa_pkg::OP_STORE: begin
				e.imm = 32'($signed({ins[31:25], ins[11:7]}));
				case (f3)
					3'd0: e.mem_op = 4'b1110;
					3'd1: e.mem_op = 4'b1111;
					3'd2: e.mem_op = 4'b1000;
					default: e.illegal = 1'b1;
				endcase
			end
			isa_pkg::OP_BRANCH: begin
				e.btype = 1'b1;
				e.pcselect = 2'b10;
				e.bneq = (f3 == 3'd1);
				e.imm = 32'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
				case (f3)
					3'd0, 3'd1: e.alu_fn = 4'b1000;
					3'd4: e.alu_fn = 4'b0010;
					3'd6: e.alu_fn = 4'b0011;
					3'd5: e.alu_fn = 4'b1001;
					3'd7: e.alu_fn = 4'b1010;
					default: e.illegal = 1'b1;
				endcase
			end
			isa_pkg::OP_JAL: begin
				e.we = 1'b1;
				e.j = 1'b1;
				e.fn = 3'b001;
				e.pcselect = 2'b10;
				e.imm = 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
			end
			isa_pkg::OP_JALR: begin
				e.we = 1'b1;
				e.jr = 1'b1;
				e.fn = 3'b001;
				e.pcselect = 2'b10;
				e.b_sel = 2'b01;
				e.imm = 32'($signed(ins[31:20]));
				e.illegal = (f3 != 3'd0);
			end
			isa_pkg::OP_LUI, isa_pkg::OP_AUIPC: begin
				e.we = 1'b1;
				e.lui = (ins[6:0] == isa_pkg::OP_LUI);
				e.auipc = ~e.lui;
				e.fn = e.lui ? 3'b011 : 3'b100;
				e.imm = {ins[31:12], 12'h000};
			end
			isa_pkg::OP_SYSTEM: begin
				e.fn = 3'b110;
				e.illegal = (f3 != 3'd0);
				e.ecall = (f3 == 3'd0) && (ins[31:20] == 12'h000);
				e.uret = (f3 == 3'd0) && (ins[31:20] == 12'h002);
				e.sret = (f3 == 3'd0) && (ins[31:20] == 12'h102);
				e.mret = (f3 == 3'd0) && (ins[31:20] == 12'h302);
			end
			default: e.illegal = 1'b1;
		endcase
		// pending exception kills the write
		if (exc) begin
			e.we = 1'b0;
		end
		return e;
	endfunction

	task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			err_field++;
			$display("error: %s expected %h got %h", name, exp, got);
		end
	endtask

	task automatic compare_fields(input pipe_pkg::issue_pkt_t e, input pipe_pkg::issue_pkt_t g);
		check_field("o_out_pc", e.pc, g.pc);
		check_field("o_out_rd", e.rd, g.rd);
		check_field("o_out_rs1", e.rs1, g.rs1);
		check_field("o_out_rs2", e.rs2, g.rs2);
		check_field("o_out_imm", e.imm, g.imm);
		check_field("o_out_b_sel", e.b_sel, g.b_sel);
		check_field("o_out_we", e.we, g.we);
		check_field("o_out_fn", e.fn, g.fn);
		check_field("o_out_alu_fn", e.alu_fn, g.alu_fn);
		check_field("o_out_muldiv_op", e.muldiv_op, g.muldiv_op);
		check_field("o_out_mem_op", e.mem_op, g.mem_op);
		check_field("o_out_pcselect", e.pcselect, g.pcselect);
		check_field("o_out_btype", e.btype, g.btype);
		check_field("o_out_bneq", e.bneq, g.bneq);
		check_field("o_out_j", e.j, g.j);
		check_field("o_out_jr", e.jr, g.jr);
		check_field("o_out_lui", e.lui, g.lui);
		check_field("o_out_auipc", e.auipc, g.auipc);
		check_field("o_out_ecall", e.ecall, g.ecall);
		check_field("o_out_mret", e.mret, g.mret);
		check_field("o_out_sret", e.sret, g.sret);
		check_field("o_out_uret", e.uret, g.uret);
		check_field("o_out_illegal", e.illegal, g.illegal);
	endtask

	// queue the expectation, then hold valid until the fetch slot takes it
	task automatic send(input logic [31:0] ins);
		logic [31:0] reads;
		logic [6:0]  op;
		op = ins[6:0];
		reads = '0;
		exp_mem[wr_ptr] = expect_decode(ins, pc_next, i_exception_pending);
		if (op != isa_pkg::OP_LUI && op != isa_pkg::OP_AUIPC && op != isa_pkg::OP_JAL) begin
			reads[ins[19:15]] = 1'b1;
		end
		if (op == isa_pkg::OP_REG || op == isa_pkg::OP_STORE || op == isa_pkg::OP_BRANCH) begin
			reads[ins[24:20]] = 1'b1;
		end
		// x0 never waits
		reads[0] = 1'b0;
		exp_reads[wr_ptr] = reads;
		wr_ptr++;
		i_in_valid = 1'b1;
		i_in_pc    = pc_next;
		i_in_instr = ins;
		do begin
			@(posedge i_clk);
			#1;
		end while (!in_took);
		i_in_valid = 1'b0;
		pc_next    = pc_next + 4;
	endtask

	// registers kept to x0..x7 so hazards come often
	task automatic send_op(input logic [6:0] op, input logic [2:0] f3, input logic [6:0] f7);
		logic [31:0] r;
		r = $random(seed);
		send({f7, 2'b00, r[2:0], 2'b00, r[5:3], f3, 2'b00, r[8:6], op});
	endtask

	// all items out and every producer written back
	task automatic drain();
		while (rd_ptr != wr_ptr || wb_q.size() != 0) begin
			@(posedge i_clk);
			#1;
		end
		repeat (2) @(posedge i_clk);
		#1;
	endtask

	// transfer tracking and the testbench's own busy model
	always @(posedge i_clk) begin
		in_took <= i_in_valid && o_in_ready;
		if (!i_rst_n) begin
			rd_ptr  <= 0;
			tb_busy <= '0;
		end else begin
			if (i_wb_valid) begin
				tb_busy[i_wb_rd] <= 1'b0;
			end
			if (o_out_valid && i_out_ready) begin
				rd_ptr <= rd_ptr + 1;
				if (exp_head.we && exp_head.rd != '0) begin
					tb_busy[exp_head.rd] <= 1'b1;
					wb_q.push_back(exp_head.rd);
				end
			end
		end
	end

	fields_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(o_out_valid && i_out_ready) |-> (act === exp_head))
		else compare_fields($sampled(exp_head), $sampled(act));

	// reader leaves only after its producer was released
	hazard_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(o_out_valid && i_out_ready) |-> ((reads_head & tb_busy) == '0))
		else begin
			err_hazard++;
			$display("hazard: item at pc %h issued before its source was written back",
				$sampled(act.pc));
		end

	hold_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(act)))
		else begin
			err_flow++;
			$display("back-pressure: held output item was dropped or changed");
		end

	// fetch slot filled behind a stuck issue slot
	full_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(o_out_valid && !i_out_ready && i_in_valid && o_in_ready) |=>
		(i_out_ready || !o_in_ready))
		else begin
			err_flow++;
			$display("back-pressure: input still ready with both slots full");
		end

	reset_a: assert property (@(posedge i_clk) !i_rst_n |=> (!o_out_valid && o_in_ready))
		else begin
			err_flow++;
			$display("reset: stage not empty and ready after a reset edge");
		end

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	// execute side, fixed stall pattern plus forced holds
	initial begin : out_ready_drv
		int cyc;
		cyc = 0;
		forever begin
			@(posedge i_clk);
			#1;
			cyc++;
			if (bp_left > 0) begin
				bp_left--;
				i_out_ready = 1'b0;
			end else begin
				i_out_ready = (cyc % 5 != 3);
			end
		end
	end

	// commit side, oldest producer released every third cycle
	initial begin : wb_drv
		int cnt;
		cnt = 0;
		forever begin
			@(posedge i_clk);
			#1;
			cnt++;
			if (wb_q.size() > 0 && cnt % 3 == 0) begin
				i_wb_valid = 1'b1;
				i_wb_rd    = wb_q.pop_front();
			end else begin
				i_wb_valid = 1'b0;
			end
		end
	end

	initial begin
		repeat (N_TESTS * 20) @(posedge i_clk);
		$display("timeout: decode stage stopped making progress");
		$display("errors: fields %0d, hazards %0d, flow %0d", err_field, err_hazard, err_flow);
		$display("sim failed");
		$finish;
	end

	initial begin : stimulus
		int          f;
		logic [31:0] r;
		logic [6:0]  op;
		logic [6:0]  ops [0:10];
		i_rst_n = 1'b0;
		i_in_valid = 1'b0;
		i_in_pc = '0;
		i_in_instr = '0;
		i_exception_pending = 1'b0;
		i_wb_valid = 1'b0;
		i_wb_rd = '0;
		i_out_ready = 1'b0;
		seed = 32'h5876_f7fb;
		wr_ptr = 0;
		bp_left = 0;
		err_field = 0;
		err_hazard = 0;
		err_flow = 0;
		pc_next = 32'h0000_1000;
		ops = '{isa_pkg::OP_REG, isa_pkg::OP_IMM, isa_pkg::OP_LOAD, isa_pkg::OP_STORE,
			isa_pkg::OP_BRANCH, isa_pkg::OP_JAL, isa_pkg::OP_JALR, isa_pkg::OP_LUI,
			isa_pkg::OP_AUIPC, isa_pkg::OP_SYSTEM, 7'b0001011};
		repeat (5) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;

		// alu, sub/sra, mul/div and immediate forms over every funct3
		for (f = 0; f < 8; f++) begin
			send_op(isa_pkg::OP_REG, f[2:0], 7'h00);
			send_op(isa_pkg::OP_REG, f[2:0], 7'h20);
			send_op(isa_pkg::OP_REG, f[2:0], 7'h01);
			send_op(isa_pkg::OP_IMM, f[2:0], 7'($random(seed)));
		end
		// memory and branch tables, reserved funct3 included
		for (f = 0; f < 8; f++) begin
			send_op(isa_pkg::OP_LOAD, f[2:0], 7'($random(seed)));
			send_op(isa_pkg::OP_STORE, f[2:0], 7'($random(seed)));
			send_op(isa_pkg::OP_BRANCH, f[2:0], 7'($random(seed)));
		end
		send_op(isa_pkg::OP_JAL, 3'($random(seed)), 7'($random(seed)));
		send_op(isa_pkg::OP_JALR, 3'd0, 7'($random(seed)));
		send_op(isa_pkg::OP_JALR, 3'd1, 7'($random(seed)));
		send_op(isa_pkg::OP_LUI, 3'($random(seed)), 7'($random(seed)));
		send_op(isa_pkg::OP_AUIPC, 3'($random(seed)), 7'($random(seed)));
		// ecall, mret, sret, uret
		send({12'h000, 5'd0, 3'd0, 5'd0, isa_pkg::OP_SYSTEM});
		send({12'h302, 5'd0, 3'd0, 5'd0, isa_pkg::OP_SYSTEM});
		send({12'h102, 5'd0, 3'd0, 5'd0, isa_pkg::OP_SYSTEM});
		send({12'h002, 5'd0, 3'd0, 5'd0, isa_pkg::OP_SYSTEM});
		send_op(7'b0001011, 3'd0, 7'd0);
		send_op(7'b1111111, 3'd2, 7'd0);

		// addi x3 then add x4, x3, x3 waits for writeback
		drain();
		send({12'h001, 5'd0, 3'd0, 5'd3, isa_pkg::OP_IMM});
		send({7'h00, 5'd3, 5'd3, 3'd0, 5'd4, isa_pkg::OP_REG});

		// hold execute off long enough to fill both slots
		drain();
		bp_left = 12;
		@(posedge i_clk);
		#1;
		send_op(isa_pkg::OP_IMM, 3'd0, 7'($random(seed)));
		while (!o_out_valid) begin
			@(posedge i_clk);
			#1;
		end
		send_op(isa_pkg::OP_REG, 3'd0, 7'h00);
		send_op(isa_pkg::OP_REG, 3'd4, 7'h00);

		// writers to x5 and x6 decoded under an exception
		drain();
		i_exception_pending = 1'b1;
		send({12'h005, 5'd1, 3'd0, 5'd5, isa_pkg::OP_IMM});
		send({20'h12345, 5'd6, isa_pkg::OP_LUI});
		drain();
		i_exception_pending = 1'b0;
		send({7'h00, 5'd6, 5'd5, 3'd0, 5'd7, isa_pkg::OP_REG});

		for (f = 0; f < N_RANDOM; f++) begin
			r  = $random(seed);
			op = ops[r[7:4] % 11];
			if (op == isa_pkg::OP_REG) begin
				send_op(op, r[14:12], r[25] ? 7'h01 : {1'b0, r[26], 5'b0});
			end else begin
				send_op(op, r[14:12], r[31:25]);
			end
		end

		drain();
		$display("errors: fields %0d, hazards %0d, flow %0d", err_field, err_hazard, err_flow);
		if (err_field + err_hazard + err_flow == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/pipe_stage.sv
design/instr_decoder.sv
design/imm_gen.sv
design/scoreboard.sv
design/decode_stage.sv
tb/tb_decode_stage.sv
